// File: all.f
verilog/cachePkg.sv
verilog/cacheController.sv
verilog/burstCounter.sv
verilog/wayStorage.sv
verilog/waySelect.sv
verilog/dataCache.sv
verification/cacheChecker.sv
verification/dataCacheProperties.sv
verification/dataCacheTb.sv

// File: runSim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module dataCacheTb -o simv \
  || exit 1
./obj_dir/simv > sim.log 2>&1 ; cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log

// File: verification/cacheChecker.sv
`timescale 1ns/1ns
`default_nettype none

module cacheChecker (
  input  logic             clk,
  input  logic             reset,
  input  cachePkg::cpuReqT cpuReq,
  input  logic [31:0]      readData,
  input  logic             stall,
  input  cachePkg::busReqT busReq,
  input  logic             busReady,
  input  logic [31:0]      expectedData,
  input  logic [31:0]      expectedBeats,
  input  logic             memCheck,
  input  logic [31:0]      memValue,
  output int               dataErrors,
  output int               beatErrors,
  output int               memErrors,
  output int               resetErrors
);

  logic access;
  int   beatCount;

  assign access = cpuReq.memRead || cpuReq.memWrite;

  initial begin
    dataErrors = 0;
    beatErrors = 0;
    memErrors = 0;
    resetErrors = 0;
    beatCount = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      if (stall || busReq.request) begin
        $display("MISMATCH time=%0t signal=stall/busRequest got=%b/%b expected=0/0",
                 $time, stall, busReq.request);
        resetErrors = resetErrors + 1;
      end
      beatCount = 0;
    end else begin
      // Operation ends on the first edge with stall low
      if (access && !stall) begin
        if (beatCount != int'(expectedBeats)) begin
          $display("MISMATCH time=%0t signal=writeBeats got=%0d expected=%0d",
                   $time, beatCount, expectedBeats);
          beatErrors = beatErrors + 1;
        end
        beatCount = 0;
        if (cpuReq.memRead && (readData !== expectedData)) begin
          $display("MISMATCH time=%0t signal=readData got=%h expected=%h",
                   $time, readData, expectedData);
          dataErrors = dataErrors + 1;
        end
      end else if (busReq.request && busReq.write && busReady) begin
        beatCount = beatCount + 1;
      end
      if (memCheck && (memValue !== expectedData)) begin
        $display("MISMATCH time=%0t signal=memWord got=%h expected=%h",
                 $time, memValue, expectedData);
        memErrors = memErrors + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/cacheGolden.txt
# op: 1 read, 2 write, 3 memory check; all columns hex
# op enable mask address data beats (data is write data or expected value)
1 1 f 00000100 5a5a0100 0
1 1 f 00000104 5a5a0104 0
2 1 3 00000108 1111aaaa 0
1 1 f 00000108 5a5aaaaa 0
2 1 f 00000210 deadbeef 0
1 1 f 00000310 5a5a0310 0
1 1 f 00000410 5a5a0410 4
3 1 f 00000210 deadbeef 0
3 1 f 00000214 5a5a0214 0
3 1 f 0000021c 5a5a021c 0
1 1 f 00000310 5a5a0310 0
2 1 c 0000031c 77770000 0
1 1 f 00000414 5a5a0414 0
1 1 f 00000510 5a5a0510 4
3 1 f 0000031c 7777031c 0
1 1 f 00000214 5a5a0214 0
1 1 f 00000210 deadbeef 0
2 0 f 00000054 cafe0054 1
3 0 f 00000054 cafe0054 0
1 0 f 00000054 cafe0054 0
1 0 f 00000058 5a5a0058 0
1 1 f 00000100 5a5a0100 0

// File: verification/dataCacheProperties.sv
`timescale 1ns/1ns
`default_nettype none

module dataCacheProperties (
  input logic                clk,
  input logic                reset,
  input cachePkg::ctrlStateT state,
  input logic                stall,
  input logic                busRequest,
  input logic                busWrite,
  input logic                busReady,
  input cachePkg::wayCtrlT   wayCtrl
);

  // Processor held for the whole of a refill or write-back
  stallInBurst: assert property (@(posedge clk) disable iff (reset)
    ((state == cachePkg::memRead) || (state == cachePkg::writeBack)) |-> stall)
    else $error("stall low while the controller runs a bus burst");

  // Quiet outputs while reset is held
  quietInReset: assert property (@(posedge clk)
    reset |-> (!stall && !busRequest && !busWrite && !wayCtrl.cacheWrite))
    else $error("controller outputs active during reset");

  // A bus beat waits for busReady with the state frozen
  heldUntilReady: assert property (@(posedge clk) disable iff (reset)
    (busRequest && !busReady) |=> (busRequest && stall && $stable(state)))
    else $error("bus request dropped or state moved before busReady");

endmodule

bind cacheController dataCacheProperties props (
  .clk, .reset, .state, .stall, .busRequest, .busWrite, .busReady, .wayCtrl
);

`default_nettype wire

// File: verification/dataCacheTb.sv
`timescale 1ns/1ns
`default_nettype none

module dataCacheTb;

  logic             clk;
  logic             reset;
  logic             enable;
  logic             instrStall;
  logic             busReady;
  cachePkg::cpuReqT cpuReq;
  logic [31:0]      writeData;
  logic [31:0]      busReadData;
  logic [31:0]      readData;
  logic             stall;
  cachePkg::busReqT busReq;

  logic [31:0] expectedData;
  logic [31:0] expectedBeats;
  logic        memCheck;
  logic [31:0] memValue;
  int dataErrors;
  int beatErrors;
  int memErrors;
  int resetErrors;
  int fileErrors;

  // Golden operations
  logic [31:0] opKind [64];
  logic [31:0] opEnable [64];
  logic [31:0] opMask [64];
  logic [31:0] opAddr [64];
  logic [31:0] opData [64];
  logic [31:0] opBeats [64];
  int opCount;

  // Backing memory, 4 KB
  logic [31:0] mem [1024];
  int seed;
  int waitCycles;

  dataCache #(.setCount(16), .blockWords(4)) uut (
    .clk, .reset, .enable, .instrStall, .busReady, .cpuReq, .writeData, .busReadData,
    .readData, .stall, .busReq
  );

  cacheChecker cacheCheck (
    .clk, .reset, .cpuReq, .readData, .stall, .busReq, .busReady, .expectedData,
    .expectedBeats, .memCheck, .memValue, .dataErrors, .beatErrors, .memErrors, .resetErrors
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic loadGolden();
    int fd;
    int n;
    logic [8*128-1:0] line;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    opCount = 0;
    fd = $fopen("verification/cacheGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file");
      fileErrors = fileErrors + 1;
    end else begin
      while (!$feof(fd) && (opCount < 64)) begin
        line = '0;
        n = $fgets(line, fd);
        // Comment and blank lines give fewer than six fields
        n = $sscanf(line, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
        if (n == 6) begin
          opKind[opCount] = f0;
          opEnable[opCount] = f1;
          opMask[opCount] = f2;
          opAddr[opCount] = f3;
          opData[opCount] = f4;
          opBeats[opCount] = f5;
          opCount = opCount + 1;
        end
      end
      $fclose(fd);
      if (opCount == 0) begin
        $display("Golden file holds no operations");
        fileErrors = fileErrors + 1;
      end
    end
  endtask

  task automatic runOp(input int k);
    @(negedge clk);
    enable = opEnable[k][0];
    expectedData = opData[k];
    expectedBeats = opBeats[k];
    cpuReq.address = opAddr[k];
    cpuReq.byteMask = opMask[k][3:0];
    writeData = opData[k];
    if (opKind[k] == 32'd3) begin
      cpuReq.memRead = 1'b0;
      cpuReq.memWrite = 1'b0;
      memValue = mem[opAddr[k][11:2]];
      memCheck = 1'b1;
      @(posedge clk);
      @(negedge clk);
      memCheck = 1'b0;
    end else begin
      cpuReq.memRead = (opKind[k] == 32'd1);
      cpuReq.memWrite = (opKind[k] == 32'd2);
      // Wait for the edge that completes the access
      @(posedge clk);
      while (stall) begin
        @(posedge clk);
      end
    end
  endtask

  task automatic finishRun();
    int total;
    total = dataErrors + beatErrors + memErrors + resetErrors + fileErrors;
    $display("Errors: read data %0d, write beats %0d, memory %0d, reset %0d, golden file %0d",
             dataErrors, beatErrors, memErrors, resetErrors, fileErrors);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // Stimulus
  initial begin
    reset = 1'b1;
    enable = 1'b1;
    instrStall = 1'b0;
    cpuReq = '0;
    writeData = '0;
    expectedData = '0;
    expectedBeats = '0;
    memCheck = 1'b0;
    memValue = '0;
    fileErrors = 0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {20'h0, 10'(i), 2'b00} ^ 32'h5a5a0000;
    end
    loadGolden();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int k = 0; k < opCount; k++) begin
      runOp(k);
    end
    @(negedge clk);
    cpuReq = '0;
    repeat (2) @(posedge clk);
    finishRun();
  end

  // Bus memory model with random ready delays
  initial begin
    busReady = 1'b0;
    busReadData = '0;
    seed = 32'h7caa9476;
    waitCycles = 0;
    forever begin
      @(negedge clk);
      if (busReady) begin
        busReady = 1'b0;
        waitCycles = $random(seed) & 32'd3;
      end else if (busReq.request && !reset) begin
        if (waitCycles > 0) begin
          waitCycles = waitCycles - 1;
        end else begin
          if (busReq.write) begin
            mem[busReq.address[11:2]] = busReq.writeData;
          end else begin
            busReadData = mem[busReq.address[11:2]];
          end
          busReady = 1'b1;
        end
      end
    end
  end

  // Watchdog scaled by the operation count
  initial begin
    @(negedge reset);
    repeat ((opCount + 1) * 200) @(posedge clk);
    $display("Timeout: the cache did not finish the operations in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/burstCounter.sv
`timescale 1ns/1ns
`default_nettype none

module burstCounter #(
  parameter int blockWords = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          busReady,
  input  logic                          counterClear,
  input  logic                          busWrite,
  input  logic                          enable,
  input  logic [$clog2(blockWords)-1:0] wordOffset,
  output logic [$clog2(blockWords)-1:0] blockWordOffset,
  output logic                          burstLast
);

  localparam int offsetBits = $clog2(blockWords);

  logic [offsetBits-1:0] count;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (counterClear) begin
      count <= '0;
    end else if (busReady) begin
      if (burstLast) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign burstLast = (count == offsetBits'(blockWords - 1));

  // An uncached store addresses its own word, not a block
  assign blockWordOffset = (counterClear || (!enable && busWrite)) ? wordOffset : count;

endmodule

`default_nettype wire

// File: verilog/cacheController.sv
`timescale 1ns/1ns
`default_nettype none

module cacheController (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  input  logic              instrStall,
  input  logic              hit,
  input  logic              victimDirty,
  input  logic              burstLast,
  input  logic              busReady,
  input  cachePkg::cpuReqT  cpuReq,
  output logic              stall,
  output logic              busRequest,
  output logic              busWrite,
  output logic              counterClear,
  output cachePkg::wayCtrlT wayCtrl,
  output logic [1:0]        readSource
);

  cachePkg::ctrlStateT state;
  cachePkg::ctrlStateT nextState;
  logic access;
  logic fillState;
  logic idleState;

  assign access = cpuReq.memRead | cpuReq.memWrite;

  // Refill beats into a way, cached or not
  assign fillState = (state == cachePkg::memRead) || (state == cachePkg::disabled);

  // States where the processor is not held
  assign idleState = (state == cachePkg::ready) || (state == cachePkg::nextInstr) ||
                     (state == cachePkg::waitInstr);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= cachePkg::ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::ready: begin
        if (access && !hit) begin
          if (cpuReq.memWrite && !enable) begin
            nextState = cachePkg::write;
          end else if (victimDirty) begin
            nextState = cachePkg::writeBack;
          end else if (enable) begin
            nextState = cachePkg::memRead;
          end else begin
            nextState = cachePkg::disabled;
          end
        end
      end
      // Victim block goes out before the refill starts
      cachePkg::writeBack: begin
        if (busReady && burstLast) begin
          nextState = cachePkg::memRead;
        end
      end
      cachePkg::memRead,
      cachePkg::disabled: begin
        if (busReady && burstLast) begin
          nextState = cachePkg::nextInstr;
        end
      end
      // Single uncached word
      cachePkg::write: begin
        if (busReady) begin
          nextState = cachePkg::nextInstr;
        end
      end
      cachePkg::nextInstr,
      cachePkg::waitInstr: begin
        nextState = instrStall ? cachePkg::waitInstr : cachePkg::ready;
      end
      default: begin
        nextState = cachePkg::ready;
      end
    endcase
  end

  assign stall = fillState || (state == cachePkg::writeBack) || (state == cachePkg::write) ||
                 ((state == cachePkg::ready) && access && !hit);

  assign busRequest = fillState || (state == cachePkg::writeBack) ||
                      (state == cachePkg::write);
  assign busWrite = (state == cachePkg::writeBack) || (state == cachePkg::write);

  // Counter held at zero outside of bursts
  assign counterClear = idleState;

  always_comb begin
    wayCtrl.blockWrite = 1'b0;
    wayCtrl.useWriteData = 1'b0;
    wayCtrl.activeByteMask = 4'hf;
    wayCtrl.cacheWrite = 1'b0;
    if (fillState && busReady) begin
      wayCtrl.blockWrite = 1'b1;
      wayCtrl.cacheWrite = 1'b1;
    end else if (((state == cachePkg::ready) || (state == cachePkg::nextInstr)) &&
                 cpuReq.memWrite && hit) begin
      // Store hit, or the store that caused the refill just finished
      wayCtrl.useWriteData = 1'b1;
      wayCtrl.activeByteMask = cpuReq.byteMask;
      wayCtrl.cacheWrite = 1'b1;
    end
  end

  // Bit 0 selects the way word
  // Bit 1 selects the word on the bus
  always_comb begin
    readSource = 2'b00;
    if (idleState && cpuReq.memRead && (hit || (state != cachePkg::ready))) begin
      readSource = 2'b01;
    end else if (fillState && busReady) begin
      readSource = 2'b10;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cachePkg.sv
`default_nettype none

package cachePkg;

  // Data path word width
  localparam int wordBits = 32;

  // Tag width for 16 sets of 4-word blocks
  // Has to agree with setCount and blockWords in dataCache
  localparam int tagBits = 24;

  // Processor address split for the cache lookup
  typedef struct packed {
    logic [tagBits-1:0] tag;
    logic [3:0]         setIndex;
    logic [1:0]         wordOffset;
    logic [1:0]         byteOffset;
  } cacheAddrT;

  // Same address word seen raw or split into fields
  typedef union packed {
    logic [wordBits-1:0] raw;
    cacheAddrT           fields;
  } cacheAddrU;

  typedef enum logic [2:0] {
    ready,
    memRead,
    writeBack,
    write,
    nextInstr,
    waitInstr,
    disabled
  } ctrlStateT;

  typedef struct packed {
    logic                memRead;
    logic                memWrite;
    logic [3:0]          byteMask;
    logic [wordBits-1:0] address;
  } cpuReqT;

  typedef struct packed {
    logic                request;
    logic                write;
    logic [wordBits-1:0] address;
    logic [wordBits-1:0] writeData;
  } busReqT;

  // Write controls shared by both ways
  typedef struct packed {
    logic       blockWrite;
    logic       useWriteData;
    logic [3:0] activeByteMask;
    logic       cacheWrite;
  } wayCtrlT;

endpackage

`default_nettype wire

// File: verilog/dataCache.sv
`timescale 1ns/1ns
`default_nettype none

module dataCache #(
  parameter int setCount = 16,
  parameter int blockWords = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,
  input  logic             instrStall,
  input  logic             busReady,
  input  cachePkg::cpuReqT cpuReq,
  input  logic [31:0]      writeData,
  input  logic [31:0]      busReadData,
  output logic [31:0]      readData,
  output logic             stall,
  output cachePkg::busReqT busReq
);

  cachePkg::cacheAddrU reqAddr;
  cachePkg::cacheAddrT busAddr;
  cachePkg::wayCtrlT   wayCtrl;

  logic [$clog2(setCount)-1:0]   setIndex;
  logic [$clog2(blockWords)-1:0] blockWordOffset;
  logic [cachePkg::tagBits-1:0]  way1Tag;
  logic [cachePkg::tagBits-1:0]  way2Tag;
  logic [cachePkg::tagBits-1:0]  victimTag;
  logic [31:0] way1Word;
  logic [31:0] way2Word;
  logic [1:0]  readSource;
  logic hit;
  logic victimDirty;
  logic burstLast;
  logic counterClear;
  logic busRequest;
  logic busWrite;
  logic way1Select;
  logic way1Fill;
  logic way1Valid;
  logic way2Valid;
  logic way1Dirty;
  logic way2Dirty;
  logic dirtyIn;
  logic uncachedWrite;

  assign reqAddr.raw = cpuReq.address;
  assign setIndex = reqAddr.fields.setIndex;
  assign dirtyIn = enable && cpuReq.memWrite;
  assign uncachedWrite = busWrite && !enable;

  cacheController controller (
    .clk, .reset, .enable, .instrStall, .hit, .victimDirty, .burstLast, .busReady,
    .cpuReq, .stall, .busRequest, .busWrite, .counterClear, .wayCtrl, .readSource
  );

  burstCounter #(.blockWords(blockWords)) counter (
    .clk, .reset, .busReady, .counterClear, .busWrite, .enable,
    .wordOffset(reqAddr.fields.wordOffset), .blockWordOffset, .burstLast
  );

  wayStorage #(.setCount(setCount), .blockWords(blockWords)) way1 (
    .clk, .reset, .setIndex, .blockWordOffset, .wayCtrl, .wayWrite(way1Fill), .dirtyIn,
    .tagIn(reqAddr.fields.tag), .writeData, .busReadData,
    .valid(way1Valid), .dirty(way1Dirty), .tag(way1Tag), .readWord(way1Word)
  );

  wayStorage #(.setCount(setCount), .blockWords(blockWords)) way2 (
    .clk, .reset, .setIndex, .blockWordOffset, .wayCtrl, .wayWrite(!way1Fill), .dirtyIn,
    .tagIn(reqAddr.fields.tag), .writeData, .busReadData,
    .valid(way2Valid), .dirty(way2Dirty), .tag(way2Tag), .readWord(way2Word)
  );

  waySelect #(.setCount(setCount)) selector (
    .clk, .reset, .enable, .way1Valid, .way2Valid, .way1Dirty, .way2Dirty,
    .cacheWrite(wayCtrl.cacheWrite), .readHitEvent(hit && cpuReq.memRead), .setIndex,
    .reqTag(reqAddr.fields.tag), .way1Tag, .way2Tag,
    .hit, .way1Select, .way1Fill, .victimDirty, .victimTag
  );

  // Write-back bursts use the victim's tag
  always_comb begin
    busAddr.tag = (busWrite && !uncachedWrite) ? victimTag : reqAddr.fields.tag;
    busAddr.setIndex = setIndex;
    busAddr.wordOffset = blockWordOffset;
    busAddr.byteOffset = 2'b00;
  end

  always_comb begin
    busReq.request = busRequest;
    busReq.write = busWrite;
    busReq.address = busAddr;
    busReq.writeData = uncachedWrite ? writeData : (way1Fill ? way1Word : way2Word);
  end

  always_comb begin
    case (readSource)
      2'b01:   readData = way1Select ? way1Word : way2Word;
      2'b10:   readData = busReadData;
      default: readData = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/waySelect.sv
`timescale 1ns/1ns
`default_nettype none

module waySelect #(
  parameter int setCount = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic                         way1Valid,
  input  logic                         way2Valid,
  input  logic                         way1Dirty,
  input  logic                         way2Dirty,
  input  logic                         cacheWrite,
  input  logic                         readHitEvent,
  input  logic [$clog2(setCount)-1:0]  setIndex,
  input  logic [cachePkg::tagBits-1:0] reqTag,
  input  logic [cachePkg::tagBits-1:0] way1Tag,
  input  logic [cachePkg::tagBits-1:0] way2Tag,
  output logic                         hit,
  output logic                         way1Select,
  output logic                         way1Fill,
  output logic                         victimDirty,
  output logic [cachePkg::tagBits-1:0] victimTag
);

  // Set bit means way 1 is the least recently used one
  logic [setCount-1:0] lruWay1;
  logic way1Hit;
  logic way2Hit;

  assign way1Hit = way1Valid && (reqTag == way1Tag);
  assign way2Hit = way2Valid && (reqTag == way2Tag);
  assign hit = enable && (way1Hit || way2Hit);

  // Uncached traffic always goes through way 1
  assign way1Select = !enable || way1Hit;

  always_comb begin
    if (!enable || way1Hit) begin
      way1Fill = 1'b1;
    end else if (way2Hit) begin
      way1Fill = 1'b0;
    end else if (!way1Valid) begin
      way1Fill = 1'b1;
    end else if (!way2Valid) begin
      way1Fill = 1'b0;
    end else begin
      way1Fill = lruWay1[setIndex];
    end
  end

  assign victimTag = way1Fill ? way1Tag : way2Tag;

  // Dirty only counts for a valid line and a live cache
  assign victimDirty = enable && (way1Fill ? (way1Valid && way1Dirty) :
                                             (way2Valid && way2Dirty));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruWay1 <= '0;
    end else if (cacheWrite || readHitEvent) begin
      lruWay1[setIndex] <= !way1Fill;
    end
  end

endmodule

`default_nettype wire

// File: verilog/wayStorage.sv
`timescale 1ns/1ns
`default_nettype none

module wayStorage #(
  parameter int setCount = 16,
  parameter int blockWords = 4
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [$clog2(setCount)-1:0]        setIndex,
  input  logic [$clog2(blockWords)-1:0]      blockWordOffset,
  input  cachePkg::wayCtrlT                  wayCtrl,
  input  logic                               wayWrite,
  input  logic                               dirtyIn,
  input  logic [cachePkg::tagBits-1:0]       tagIn,
  input  logic [31:0]                        writeData,
  input  logic [31:0]                        busReadData,
  output logic                               valid,
  output logic                               dirty,
  output logic [cachePkg::tagBits-1:0]       tag,
  output logic [31:0]                        readWord
);

  localparam int setBits = $clog2(setCount);
  localparam int offsetBits = $clog2(blockWords);

  logic [cachePkg::tagBits-1:0]  tagArray [setCount];
  logic [cachePkg::wordBits-1:0] dataArray [setCount * blockWords];
  logic [setCount-1:0]           validBits;
  logic [setCount-1:0]           dirtyBits;
  logic [setBits+offsetBits-1:0] wordIndex;
  logic [cachePkg::wordBits-1:0] newWord;
  logic                          writeEnable;

  // Word address inside this way
  assign wordIndex = {setIndex, blockWordOffset};

  assign writeEnable = wayWrite && wayCtrl.cacheWrite;
  assign newWord = wayCtrl.useWriteData ? writeData : busReadData;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (writeEnable) begin
      if (wayCtrl.blockWrite) begin
        validBits[setIndex] <= 1'b1;
      end
      dirtyBits[setIndex] <= dirtyIn;
    end
  end

  always_ff @(posedge clk) begin
    if (writeEnable) begin
      // Refill beats come in with every byte enabled
      for (int b = 0; b < 4; b++) begin
        if (wayCtrl.activeByteMask[b]) begin
          dataArray[wordIndex][8*b +: 8] <= newWord[8*b +: 8];
        end
      end
      if (wayCtrl.blockWrite) begin
        tagArray[setIndex] <= tagIn;
      end
    end
  end

  assign valid = validBits[setIndex];
  assign dirty = dirtyBits[setIndex];
  assign tag = tagArray[setIndex];
  assign readWord = dataArray[wordIndex];

endmodule

`default_nettype wire
